/* hw/uc_cfg_regs.sv */
`include "uc_params.svh"

module uc_cfg_regs
  import uc_msg_pkg::*;
  import uc_map_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,

  input  uc_msg_s cmd_i,
  input  logic    cmd_v_i,
  output logic    cmd_ready_o,

  output uc_msg_s resp_o,
  output logic    resp_v_o,
  input  logic    resp_yumi_i,

  output logic    freeze_o
);

  uc_paddr_u             addr;
  logic                  accept, is_dev, wr;
  logic                  freeze_r;
  logic [`UC_DATA_W-1:0] scratch_r [2];
  logic [`UC_DATA_W-1:0] rd_data;
  logic                  resp_v_r;
  uc_msg_s               resp_r;

  assign addr        = cmd_i.header.addr;
  assign is_dev      = (addr.loc.dev == `UC_CFG_DEV);
  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign wr          = accept & is_dev & (cmd_i.header.kind == e_uc_write);

  // Unmatched local addresses land here and read as zero
  always_comb
    begin
      rd_data = '0;
      if (is_dev)
        case (addr.loc.offset)
          `UC_CFG_FREEZE_OFS:         rd_data = `UC_DATA_W'(freeze_r);
          `UC_CFG_SCRATCH_OFS:        rd_data = scratch_r[0];
          `UC_CFG_SCRATCH_OFS + 20'h8: rd_data = scratch_r[1];
          default:                    rd_data = '0;
        endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          freeze_r     <= 1'b1;
          scratch_r[0] <= '0;
          scratch_r[1] <= '0;
          resp_v_r     <= 1'b0;
        end
      else
        begin
          if (wr)
            case (addr.loc.offset)
              `UC_CFG_FREEZE_OFS:          freeze_r     <= cmd_i.data[0];
              `UC_CFG_SCRATCH_OFS:         scratch_r[0] <= cmd_i.data;
              `UC_CFG_SCRATCH_OFS + 20'h8: scratch_r[1] <= cmd_i.data;
              default:                     ;
            endcase
          if (accept)
            resp_v_r <= 1'b1;
          else if (resp_yumi_i)
            resp_v_r <= 1'b0;
        end
    end

  // Writes answer with zero data
  always_ff @(posedge clk_i)
    if (accept)
      begin
        resp_r.header <= cmd_i.header;
        resp_r.data   <= (cmd_i.header.kind == e_uc_write) ? '0 : rd_data;
      end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;
  assign freeze_o = freeze_r;

endmodule

/* hw/uc_clint.sv */
`include "uc_params.svh"

module uc_clint
  import uc_msg_pkg::*;
  import uc_map_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,

  input  uc_msg_s cmd_i,
  input  logic    cmd_v_i,
  output logic    cmd_ready_o,

  output uc_msg_s resp_o,
  output logic    resp_v_o,
  input  logic    resp_yumi_i,

  output logic    timer_irq_o,
  output logic    software_irq_o
);

  uc_paddr_u             addr;
  logic                  accept, wr;
  logic [`UC_DATA_W-1:0] mtime_r, mtimecmp_r;
  logic                  msip_r;
  logic [`UC_DATA_W-1:0] rd_data;
  logic                  resp_v_r;
  uc_msg_s               resp_r;

  assign addr        = cmd_i.header.addr;
  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign wr          = accept & (cmd_i.header.kind == e_uc_write);

  always_comb
    case (addr.loc.offset)
      `UC_CLINT_MSIP_OFS:     rd_data = `UC_DATA_W'(msip_r);
      `UC_CLINT_MTIMECMP_OFS: rd_data = mtimecmp_r;
      `UC_CLINT_MTIME_OFS:    rd_data = mtime_r;
      default:                rd_data = '0;
    endcase

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          mtime_r    <= '0;
          mtimecmp_r <= '1;
          msip_r     <= 1'b0;
          resp_v_r   <= 1'b0;
        end
      else
        begin
          // A write to mtime takes the place of this cycle's increment
          if (wr && (addr.loc.offset == `UC_CLINT_MTIME_OFS))
            mtime_r <= cmd_i.data;
          else
            mtime_r <= mtime_r + 1'b1;
          if (wr && (addr.loc.offset == `UC_CLINT_MTIMECMP_OFS))
            mtimecmp_r <= cmd_i.data;
          if (wr && (addr.loc.offset == `UC_CLINT_MSIP_OFS))
            msip_r <= cmd_i.data[0];
          if (accept)
            resp_v_r <= 1'b1;
          else if (resp_yumi_i)
            resp_v_r <= 1'b0;
        end
    end

  always_ff @(posedge clk_i)
    if (accept)
      begin
        resp_r.header <= cmd_i.header;
        resp_r.data   <= (cmd_i.header.kind == e_uc_write) ? '0 : rd_data;
      end

  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

endmodule

/* hw/uc_cmd_router.sv */
`include "uc_params.svh"

module uc_cmd_router
  import uc_msg_pkg::*;
  import uc_map_pkg::*;
(
  input  uc_msg_s [`UC_NUM_LCE-1:0] cmd_i,
  input  logic    [`UC_NUM_LCE-1:0] cmd_v_i,
  output logic    [`UC_NUM_LCE-1:0] cmd_yumi_o,

  input  logic                      cfg_ready_i,
  input  logic                      clint_ready_i,
  input  logic                      mem_ready_i,

  output uc_msg_s                   cmd_o,
  output logic                      cfg_v_o,
  output logic                      clint_v_o,
  output logic                      mem_v_o
);

  logic       all_ready;
  logic       granted;
  uc_paddr_u  paddr;
  uc_target_e tgt;

  // A stalled target blocks every command
  assign all_ready = cfg_ready_i & clint_ready_i & mem_ready_i;

  // Highest index wins
  always_comb
    begin
      cmd_yumi_o = '0;
      cmd_o      = cmd_i[0];
      if (all_ready)
        for (int i = 0; i < `UC_NUM_LCE; i++)
          if (cmd_v_i[i])
            begin
              cmd_yumi_o    = '0;
              cmd_yumi_o[i] = 1'b1;
              cmd_o         = cmd_i[i];
            end
    end

  assign paddr   = cmd_o.header.addr;
  assign granted = |cmd_yumi_o;

  always_comb
    begin
      if ((paddr.dram >= `UC_DRAM_BASE)
          || (paddr.dram[`UC_PADDR_W-1 -: `UC_DOMAIN_W] != '0))
        tgt = e_uc_tgt_mem;
      else if (paddr.loc.dev == `UC_CLINT_DEV)
        tgt = e_uc_tgt_clint;
      else
        tgt = e_uc_tgt_cfg;
    end

  assign cfg_v_o   = granted & (tgt == e_uc_tgt_cfg);
  assign clint_v_o = granted & (tgt == e_uc_tgt_clint);
  assign mem_v_o   = granted & (tgt == e_uc_tgt_mem);

  always_comb
    if (!$isunknown(cmd_yumi_o))
      a_one_grant: assert ($onehot0(cmd_yumi_o))
        else $error("uc_cmd_router: more than one command FIFO granted");

endmodule

/* hw/uc_map_pkg.sv */
`include "uc_params.svh"

package uc_map_pkg;

  typedef struct packed
  {
    logic [`UC_PADDR_W-`UC_DEV_W-`UC_OFS_W-1:0] zero;
    logic [`UC_DEV_W-1:0]                        dev;
    logic [`UC_OFS_W-1:0]                        offset;
  } uc_local_addr_s;

  // Same bits, seen as a DRAM address or as device plus offset
  typedef union packed
  {
    logic [`UC_PADDR_W-1:0] dram;
    uc_local_addr_s         loc;
  } uc_paddr_u;

  typedef enum logic [1:0]
  {
    e_uc_tgt_cfg   = 2'd0,
    e_uc_tgt_clint = 2'd1,
    e_uc_tgt_mem   = 2'd2
  } uc_target_e;

endpackage

/* hw/uc_msg_pkg.sv */
`include "uc_params.svh"

package uc_msg_pkg;

  typedef enum logic [0:0]
  {
    e_uc_read  = 1'b0,
    e_uc_write = 1'b1
  } uc_msg_kind_e;

  typedef logic [$clog2(`UC_NUM_LCE)-1:0] uc_lce_id_t;

  // Responses carry the command header back unchanged
  typedef struct packed
  {
    uc_msg_kind_e            kind;
    logic [`UC_PADDR_W-1:0]  addr;
    uc_lce_id_t              lce_id;
  } uc_msg_hdr_s;

  typedef struct packed
  {
    uc_msg_hdr_s             header;
    logic [`UC_DATA_W-1:0]   data;
  } uc_msg_s;

endpackage

/* hw/uc_params.svh */
`ifndef UC_PARAMS_SVH
`define UC_PARAMS_SVH

// Message and address widths
`define UC_PADDR_W   40
`define UC_DATA_W    64
`define UC_NUM_LCE   2
`define UC_DOMAIN_W  3
`define UC_DEV_W     4
`define UC_OFS_W     20

`define UC_DRAM_BASE 40'h00_8000_0000

// Local device numbers, taken from address bits 23..20
`define UC_CLINT_DEV 4'd1
`define UC_CFG_DEV   4'd2

`define UC_CFG_FREEZE_OFS     20'h0
// Two scratch words, the second one a dword above this one
`define UC_CFG_SCRATCH_OFS    20'h8

`define UC_CLINT_MSIP_OFS     20'h0
`define UC_CLINT_MTIMECMP_OFS 20'h4000
`define UC_CLINT_MTIME_OFS    20'hBFF8

`endif

/* hw/uc_resp_router.sv */
`include "uc_params.svh"

module uc_resp_router
  import uc_msg_pkg::*;
  import uc_map_pkg::*;
(
  input  uc_msg_s                cfg_resp_i,
  input  logic                   cfg_resp_v_i,
  output logic                   cfg_resp_yumi_o,

  input  uc_msg_s                clint_resp_i,
  input  logic                   clint_resp_v_i,
  output logic                   clint_resp_yumi_o,

  input  uc_msg_s                mem_resp_i,
  input  logic                   mem_resp_v_i,
  output logic                   mem_resp_yumi_o,

  input  logic [`UC_NUM_LCE-1:0] fifo_ready_i,
  output uc_msg_s                resp_o,
  output logic [`UC_NUM_LCE-1:0] resp_v_o
);

  uc_target_e src;
  logic       src_v;
  logic       grant;

  // Memory first, then clint, then cfg
  always_comb
    begin
      src_v = 1'b1;
      src   = e_uc_tgt_mem;
      if (mem_resp_v_i)
        src = e_uc_tgt_mem;
      else if (clint_resp_v_i)
        src = e_uc_tgt_clint;
      else if (cfg_resp_v_i)
        src = e_uc_tgt_cfg;
      else
        src_v = 1'b0;
    end

  assign grant = src_v & (&fifo_ready_i);

  assign mem_resp_yumi_o   = grant & (src == e_uc_tgt_mem);
  assign clint_resp_yumi_o = grant & (src == e_uc_tgt_clint);
  assign cfg_resp_yumi_o   = grant & (src == e_uc_tgt_cfg);

  always_comb
    case (src)
      e_uc_tgt_cfg:   resp_o = cfg_resp_i;
      e_uc_tgt_clint: resp_o = clint_resp_i;
      default:        resp_o = mem_resp_i;
    endcase

  always_comb
    begin
      resp_v_o                       = '0;
      resp_v_o[resp_o.header.lce_id] = grant;
    end

  always_comb
    if (!$isunknown(resp_v_o))
      a_one_dest: assert ($onehot0(resp_v_o))
        else $error("uc_resp_router: response sent to more than one requester");

endmodule

/* hw/uc_two_fifo.sv */
module uc_two_fifo
  import uc_msg_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,

  input  uc_msg_s data_i,
  input  logic    v_i,
  output logic    ready_o,

  output uc_msg_s data_o,
  output logic    v_o,
  input  logic    yumi_i
);

  uc_msg_s mem_r [2];
  logic    rptr_r, wptr_r;
  logic    full_r, empty_r, ready_r;
  logic    enq, deq, full_n;

  assign enq = v_i & ready_r;
  assign deq = yumi_i;

  assign ready_o = ready_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  always_comb
    begin
      full_n = full_r;
      if (enq & ~deq)
        full_n = (~wptr_r == rptr_r);
      else if (deq & ~enq)
        full_n = 1'b0;
    end

  // Ready is its own flop so that it stays low through reset
  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          rptr_r  <= 1'b0;
          wptr_r  <= 1'b0;
          full_r  <= 1'b0;
          empty_r <= 1'b1;
          ready_r <= 1'b0;
        end
      else
        begin
          if (enq)
            wptr_r <= ~wptr_r;
          if (deq)
            rptr_r <= ~rptr_r;
          if (enq & ~deq)
            empty_r <= 1'b0;
          else if (deq & ~enq)
            empty_r <= (~rptr_r == wptr_r);
          full_r  <= full_n;
          ready_r <= ~full_n;
        end
    end

  always_ff @(posedge clk_i)
    if (enq)
      mem_r[wptr_r] <= data_i;

  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (rst_i) yumi_i |-> v_o)
    else $error("uc_two_fifo: yumi_i raised while v_o is low");

endmodule

/* hw/uc_uncore.sv */
`include "uc_params.svh"

module uc_uncore
  import uc_msg_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,

  // Requester 0 is the instruction side, 1 the data side
  input  uc_msg_s [`UC_NUM_LCE-1:0] req_cmd_i,
  input  logic    [`UC_NUM_LCE-1:0] req_cmd_v_i,
  output logic    [`UC_NUM_LCE-1:0] req_cmd_ready_o,

  output uc_msg_s [`UC_NUM_LCE-1:0] req_resp_o,
  output logic    [`UC_NUM_LCE-1:0] req_resp_v_o,
  input  logic    [`UC_NUM_LCE-1:0] req_resp_yumi_i,

  // DRAM and off-domain traffic
  output uc_msg_s                   mem_cmd_o,
  output logic                      mem_cmd_v_o,
  input  logic                      mem_cmd_ready_i,

  input  uc_msg_s                   mem_resp_i,
  input  logic                      mem_resp_v_i,
  output logic                      mem_resp_yumi_o,

  output logic                      freeze_o,
  output logic                      timer_irq_o,
  output logic                      software_irq_o
);

  uc_msg_s [`UC_NUM_LCE-1:0] cmd_fifo_lo;
  logic    [`UC_NUM_LCE-1:0] cmd_fifo_v_lo, cmd_fifo_yumi_li;
  logic    [`UC_NUM_LCE-1:0] resp_fifo_v_li, resp_fifo_ready_lo;
  uc_msg_s                   cmd_li, resp_li;

  logic    cfg_cmd_v_li, cfg_cmd_ready_lo;
  logic    clint_cmd_v_li, clint_cmd_ready_lo;
  uc_msg_s cfg_resp_lo, clint_resp_lo;
  logic    cfg_resp_v_lo, cfg_resp_yumi_li;
  logic    clint_resp_v_lo, clint_resp_yumi_li;

  for (genvar i = 0; i < `UC_NUM_LCE; i++)
    begin : g_lce
      uc_two_fifo u_cmd_fifo
      (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .data_i  (req_cmd_i[i]),
        .v_i     (req_cmd_v_i[i]),
        .ready_o (req_cmd_ready_o[i]),
        .data_o  (cmd_fifo_lo[i]),
        .v_o     (cmd_fifo_v_lo[i]),
        .yumi_i  (cmd_fifo_yumi_li[i])
      );

      uc_two_fifo u_resp_fifo
      (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .data_i  (resp_li),
        .v_i     (resp_fifo_v_li[i]),
        .ready_o (resp_fifo_ready_lo[i]),
        .data_o  (req_resp_o[i]),
        .v_o     (req_resp_v_o[i]),
        .yumi_i  (req_resp_yumi_i[i])
      );
    end

  uc_cmd_router u_cmd_router
  (
    .cmd_i         (cmd_fifo_lo),
    .cmd_v_i       (cmd_fifo_v_lo),
    .cmd_yumi_o    (cmd_fifo_yumi_li),
    .cfg_ready_i   (cfg_cmd_ready_lo),
    .clint_ready_i (clint_cmd_ready_lo),
    .mem_ready_i   (mem_cmd_ready_i),
    .cmd_o         (cmd_li),
    .cfg_v_o       (cfg_cmd_v_li),
    .clint_v_o     (clint_cmd_v_li),
    .mem_v_o       (mem_cmd_v_o)
  );

  assign mem_cmd_o = cmd_li;

  uc_cfg_regs u_cfg_regs
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_i       (cmd_li),
    .cmd_v_i     (cfg_cmd_v_li),
    .cmd_ready_o (cfg_cmd_ready_lo),
    .resp_o      (cfg_resp_lo),
    .resp_v_o    (cfg_resp_v_lo),
    .resp_yumi_i (cfg_resp_yumi_li),
    .freeze_o    (freeze_o)
  );

  uc_clint u_clint
  (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .cmd_i          (cmd_li),
    .cmd_v_i        (clint_cmd_v_li),
    .cmd_ready_o    (clint_cmd_ready_lo),
    .resp_o         (clint_resp_lo),
    .resp_v_o       (clint_resp_v_lo),
    .resp_yumi_i    (clint_resp_yumi_li),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

  uc_resp_router u_resp_router
  (
    .cfg_resp_i        (cfg_resp_lo),
    .cfg_resp_v_i      (cfg_resp_v_lo),
    .cfg_resp_yumi_o   (cfg_resp_yumi_li),
    .clint_resp_i      (clint_resp_lo),
    .clint_resp_v_i    (clint_resp_v_lo),
    .clint_resp_yumi_o (clint_resp_yumi_li),
    .mem_resp_i        (mem_resp_i),
    .mem_resp_v_i      (mem_resp_v_i),
    .mem_resp_yumi_o   (mem_resp_yumi_o),
    .fifo_ready_i      (resp_fifo_ready_lo),
    .resp_o            (resp_li),
    .resp_v_o          (resp_fifo_v_li)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the uncore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_uncore \
  -o sim_uncore
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

./obj_dir/sim_uncore > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "No result line found in sim.log"
  exit 1
fi
exit 0

/* sources.f */
+incdir+hw
hw/uc_msg_pkg.sv
hw/uc_map_pkg.sv
hw/uc_two_fifo.sv
hw/uc_cmd_router.sv
hw/uc_resp_router.sv
hw/uc_cfg_regs.sv
hw/uc_clint.sv
hw/uc_uncore.sv
verif/tb_uncore.sv

/* verif/tb_uncore.sv */
`include "uc_params.svh"

module tb_uncore
  import uc_msg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [39:0] CFG_BASE   = 40'h00_0020_0000;
  localparam logic [39:0] CLINT_BASE = 40'h00_0010_0000;

  logic clk_i, rst_i;
  uc_msg_s [1:0] req_cmd_i, req_resp_o;
  logic [1:0] req_cmd_v_i, req_cmd_ready_o, req_resp_v_o, req_resp_yumi_i;
  uc_msg_s mem_cmd_o, mem_resp_i;
  logic mem_cmd_v_o, mem_cmd_ready_i, mem_resp_v_i, mem_resp_yumi_o;
  logic freeze_o, timer_irq_o, software_irq_o;

  int seed = 32'h7e36_313d;
  int cycle = 0;
  int value_errors = 0;
  int other_errors = 0;
  logic stall_hold = 1'b0;

  uc_msg_s cmd_q [2][$];
  uc_msg_s exp_q [2][$];
  uc_msg_s mem_exp_q [2][$];
  bit      chk_q [2][$];
  string   name_q [2][$];
  logic [63:0] capt_q [$];
  uc_msg_s mem_q [$];
  int      due_q [$];
  int      last_due = 0;
  logic [1:0] cmd_sent = '0;
  logic mem_resp_done = 1'b0;

  uc_uncore u_uc_uncore (.*);

  initial
    begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
    end

  initial
    begin
      rst_i = 1'b1;
      req_cmd_i = '0;
      req_cmd_v_i = '0;
      req_resp_yumi_i = '0;
      mem_cmd_ready_i = 1'b0;
      mem_resp_i = '0;
      mem_resp_v_i = 1'b0;
    end

  task automatic finish_run();
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic check_eq(string name, logic [63:0] exp, logic [63:0] act);
    assert (exp === act)
      else
        begin
          value_errors++;
          $display("Error %s: expected %h, actual %h", name, exp, act);
        end
  endtask

  // Memory map: 2 for the memory port, 1 for clint, 0 for cfg
  function automatic int target_of(logic [39:0] addr);
    if (addr >= `UC_DRAM_BASE || addr[39:37] != 3'd0)
      return 2;
    else if (addr[23:20] == `UC_CLINT_DEV)
      return 1;
    return 0;
  endfunction

  // Queues a command and its predicted response
  task automatic issue(int lce, uc_msg_kind_e kind, logic [39:0] addr, logic [63:0] data,
                       logic [63:0] exp_data, bit chk, string name);
    uc_msg_s m;
    m.header.kind = kind;
    m.header.addr = addr;
    m.header.lce_id = lce[0];
    m.data = data;
    cmd_q[lce].push_back(m);
    if (target_of(addr) == 2)
      mem_exp_q[lce].push_back(m);
    m.data = exp_data;
    exp_q[lce].push_back(m);
    chk_q[lce].push_back(chk);
    name_q[lce].push_back(name);
  endtask

  task automatic drain();
    while (cmd_q[0].size() + cmd_q[1].size() + exp_q[0].size() + exp_q[1].size()
           + mem_q.size() != 0)
      @(posedge clk_i);
    @(negedge clk_i);
  endtask

  always @(posedge clk_i)
    begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYCLES)
        begin
          other_errors++;
          $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
          finish_run();
        end
    end

  // Monitors sample the values that were driven at the previous falling edge
  always @(posedge clk_i)
    if (!rst_i)
      begin
        for (int i = 0; i < 2; i++)
          begin
            if (req_cmd_v_i[i] && req_cmd_ready_o[i])
              cmd_sent[i] = 1'b1;
            if (req_resp_v_o[i] && req_resp_yumi_i[i])
              begin : match
                int idx;
                int tgt;
                bit overtaken;
                idx = -1;
                overtaken = 1'b0;
                tgt = target_of(req_resp_o[i].header.addr);
                for (int k = 0; k < exp_q[i].size(); k++)
                  if (idx < 0 && exp_q[i][k].header == req_resp_o[i].header)
                    idx = k;
                if (idx < 0)
                  begin
                    other_errors++;
                    $display("Unexpected or duplicated response on requester %0d, addr %h",
                             i, req_resp_o[i].header.addr);
                  end
                else
                  begin
                    // Responses from one target keep their issue order
                    for (int k = 0; k < idx; k++)
                      if (target_of(exp_q[i][k].header.addr) == tgt)
                        overtaken = 1'b1;
                    if (overtaken)
                      begin
                        other_errors++;
                        $display("Response on requester %0d came ahead of an older one, addr %h",
                                 i, req_resp_o[i].header.addr);
                      end
                    if (chk_q[i][idx])
                      check_eq(name_q[i][idx], exp_q[i][idx].data, req_resp_o[i].data);
                    else
                      capt_q.push_back(req_resp_o[i].data);
                    exp_q[i].delete(idx);
                    chk_q[i].delete(idx);
                    name_q[i].delete(idx);
                  end
              end
          end
        if (mem_cmd_v_o && mem_cmd_ready_i)
          begin : mem_accept
            int due;
            int lid;
            due = cycle + 1 + ({$random(seed)} % 4);
            if (due < last_due)
              due = last_due;
            last_due = due;
            mem_q.push_back(mem_cmd_o);
            due_q.push_back(due);
            lid = int'(mem_cmd_o.header.lce_id);
            if (mem_exp_q[lid].size() == 0)
              begin
                other_errors++;
                $display("Memory command that no requester issued, addr %h",
                         mem_cmd_o.header.addr);
              end
            else
              begin
                check_eq("mem_cmd_header", 64'(mem_exp_q[lid][0].header),
                         64'(mem_cmd_o.header));
                check_eq("mem_cmd_data", mem_exp_q[lid][0].data, mem_cmd_o.data);
                void'(mem_exp_q[lid].pop_front());
              end
          end
        if (mem_resp_v_i && mem_resp_yumi_o)
          mem_resp_done = 1'b1;
      end

  always @(negedge clk_i)
    if (!rst_i)
      begin
        for (int i = 0; i < 2; i++)
          begin
            if (cmd_sent[i])
              void'(cmd_q[i].pop_front());
            cmd_sent[i] = 1'b0;
            req_cmd_v_i[i] = (cmd_q[i].size() != 0);
            req_cmd_i[i] = (cmd_q[i].size() != 0) ? cmd_q[i][0] : '0;
            req_resp_yumi_i[i] = req_resp_v_o[i] && ({$random(seed)} % 4 != 0);
          end
        mem_cmd_ready_i = !stall_hold && ({$random(seed)} % 3 != 0);
        if (mem_resp_done)
          begin
            mem_resp_v_i = 1'b0;
            void'(mem_q.pop_front());
            void'(due_q.pop_front());
            mem_resp_done = 1'b0;
          end
        if (!mem_resp_v_i && mem_q.size() != 0 && due_q[0] <= cycle)
          begin
            mem_resp_i.header = mem_q[0].header;
            mem_resp_i.data = 64'(mem_q[0].header.addr) ^ 64'h5a5a;
            mem_resp_v_i = 1'b1;
          end
      end

  a_mem_v_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_cmd_v_o |-> mem_cmd_ready_i)
    else
      begin
        other_errors++;
        $display("Memory command offered while the memory port was not ready");
      end

  a_stall_blocks: assert property (@(posedge clk_i) disable iff (rst_i)
    stall_hold |-> (u_uc_uncore.cmd_fifo_yumi_li == '0))
    else
      begin
        other_errors++;
        $display("A command left its FIFO while the memory port was stalled");
      end

  a_reset_quiet: assert property (@(posedge clk_i) ($past(rst_i) && rst_i) |->
    (req_resp_v_o == '0 && !mem_cmd_v_o && req_cmd_ready_o == '0 && !mem_resp_yumi_o))
    else
      begin
        other_errors++;
        $display("Valid or ready output high during reset");
      end

  initial
    begin : stimulus
      logic [39:0] a;
      logic [63:0] w0, w1;
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      check_eq("reset_freeze", 64'd1, 64'(freeze_o));
      check_eq("reset_irqs", 64'd0, 64'({timer_irq_o, software_irq_o}));
      check_eq("reset_valids", 64'd0, 64'({req_resp_v_o, mem_cmd_v_o}));

      issue(1, e_uc_write, CFG_BASE, 64'd0, 64'd0, 1'b1, "freeze_wr");
      drain();
      check_eq("freeze_clear", 64'd0, 64'(freeze_o));

      w0 = {$random(seed), $random(seed)};
      w1 = {$random(seed), $random(seed)};
      issue(1, e_uc_write, CFG_BASE + 40'h8, w0, 64'd0, 1'b1, "scratch0_wr");
      issue(1, e_uc_write, CFG_BASE + 40'h10, w1, 64'd0, 1'b1, "scratch1_wr");
      issue(1, e_uc_read, CFG_BASE + 40'h8, 64'd0, w0, 1'b1, "scratch0_rd");
      issue(0, e_uc_read, CFG_BASE + 40'h10, 64'd0, w1, 1'b1, "scratch1_rd");
      issue(0, e_uc_read, CFG_BASE + 40'h40, 64'd0, 64'd0, 1'b1, "unknown_rd");
      drain();

      issue(1, e_uc_write, CLINT_BASE, 64'd1, 64'd0, 1'b1, "msip_wr");
      issue(1, e_uc_write, CLINT_BASE + 40'h4000, 64'd16, 64'd0, 1'b1, "mtimecmp_wr");
      drain();
      check_eq("software_irq", 64'd1, 64'(software_irq_o));
      check_eq("timer_irq", 64'd1, 64'(timer_irq_o));
      capt_q.delete();
      issue(0, e_uc_read, CLINT_BASE + 40'hBFF8, 64'd0, 64'd0, 1'b0, "mtime_rd0");
      drain();
      issue(0, e_uc_read, CLINT_BASE + 40'hBFF8, 64'd0, 64'd0, 1'b0, "mtime_rd1");
      drain();
      assert (capt_q.size() == 2 && capt_q[1] > capt_q[0])
        else
          begin
            other_errors++;
            $display("mtime did not increase between two reads");
          end

      issue(0, e_uc_read, `UC_DRAM_BASE + 40'h100, 64'd0, 64'h8000_0100 ^ 64'h5a5a, 1'b1,
            "dram_rd");
      issue(1, e_uc_read, 40'h20_0000_1000, 64'd0, 64'h20_0000_1000 ^ 64'h5a5a, 1'b1,
            "domain_rd");
      drain();

      for (int n = 0; n < 24; n++)
        begin
          a = `UC_DRAM_BASE + 40'(({$random(seed)} & 32'hffff) << 3);
          if ({$random(seed)} % 2 == 0)
            issue(0, e_uc_read, a, 64'd0, 64'(a) ^ 64'h5a5a, 1'b1, "mix_mem0");
          else
            issue(0, e_uc_read, CFG_BASE + 40'h80, 64'd0, 64'd0, 1'b1, "mix_cfg0");
          a = 40'h30_0000_0000 + 40'(({$random(seed)} & 32'hffff) << 3);
          if ({$random(seed)} % 2 == 0)
            issue(1, e_uc_write, a, 64'(n), 64'(a) ^ 64'h5a5a, 1'b1, "mix_mem1");
          else
            issue(1, e_uc_write, CFG_BASE + 40'h8, 64'(n), 64'd0, 1'b1, "mix_cfg1");
        end
      drain();

      stall_hold = 1'b1;
      repeat (4) @(negedge clk_i);
      for (int n = 0; n < 4; n++)
        begin
          issue(0, e_uc_read, CFG_BASE + 40'h80, 64'd0, 64'd0, 1'b1, "stall_rd0");
          issue(1, e_uc_read, CFG_BASE + 40'h80, 64'd0, 64'd0, 1'b1, "stall_rd1");
        end
      repeat (12) @(negedge clk_i);
      check_eq("stall_ready", 64'd0, 64'(req_cmd_ready_o));
      stall_hold = 1'b0;
      drain();
      finish_run();
    end

endmodule
